//--- sim.f
source/fpu_pkg.sv
source/fpu_pipe.sv
source/fpu_sign_group.sv
source/fpu_cmp_group.sv
source/fpu_rr_arbiter.sv
source/fpu_top.sv
test/fpu_tb_assert.sv
test/fpu_tb.sv

//--- source/fpu_cmp_group.sv
`timescale 1ns/100ps

module fpu_cmp_group #(
  parameter type TagType = logic
) (
  input  logic                      clk_i,
  input  logic                      arst_n_i,
  input  logic                      flush_i,
  input  fpu_pkg::operands_t        operands_i,
  input  fpu_pkg::boxed_t           boxed_i,
  input  fpu_pkg::operation_e       op_i,
  input  fpu_pkg::fp_format_e       fmt_i,
  input  TagType                    tag_i,
  input  logic                      in_valid_i,
  output logic                      in_ready_o,
  output logic [fpu_pkg::FLEN-1:0]  result_o,
  output fpu_pkg::status_t          status_o,
  output TagType                    tag_o,
  output logic                      out_valid_o,
  input  logic                      out_ready_i,
  output logic                      busy_o
);

  import fpu_pkg::*;

  typedef struct packed {
    logic [FLEN-1:0] result;
    status_t         status;
    TagType          tag;
  } out_t;

  logic [FLEN-1:0] opa;
  logic [FLEN-1:0] opb;
  logic [FLEN-1:0] mag_mask;
  logic [FLEN-1:0] mag_a;
  logic [FLEN-1:0] mag_b;
  logic            sign_a;
  logic            sign_b;
  logic            any_nan;
  logic            any_snan;
  logic            both_zero;
  logic            ident;
  logic            less;
  out_t            res_d;
  out_t            res_q;

  assign opa = boxed_i[0] ? operands_i[0] : canonical_nan(fmt_i);
  assign opb = boxed_i[1] ? operands_i[1] : canonical_nan(fmt_i);

  // ---------------------------------------------------------------------
  // Ordering of the two operands
  // ---------------------------------------------------------------------
  assign mag_mask  = {FLEN{1'b1}} >> (FLEN - fp_width(fmt_i) + 1);
  assign mag_a     = opa & mag_mask;
  assign mag_b     = opb & mag_mask;
  assign sign_a    = opa[fp_width(fmt_i)-1];
  assign sign_b    = opb[fp_width(fmt_i)-1];
  assign any_nan   = is_nan(opa, fmt_i) | is_nan(opb, fmt_i);
  assign any_snan  = is_snan(opa, fmt_i) | is_snan(opb, fmt_i);
  assign both_zero = (mag_a == '0) && (mag_b == '0);
  assign ident     = (opa == opb);

  // A below B, where -0 sorts below +0
  assign less = (sign_a != sign_b) ? sign_a :
                sign_a ? (mag_a > mag_b) : (mag_a < mag_b);

  always_comb begin
    res_d        = '0;
    res_d.tag    = tag_i;
    case (op_i)
      MIN, MAX: begin
        res_d.status.NV = any_snan;
        if (is_nan(opa, fmt_i) && is_nan(opb, fmt_i)) begin
          res_d.result = canonical_nan(fmt_i);
        end else if (is_nan(opa, fmt_i)) begin
          res_d.result = opb;
        end else if (is_nan(opb, fmt_i)) begin
          res_d.result = opa;
        end else begin
          res_d.result = (less ^ (op_i == MAX)) ? opa : opb;
        end
      end
      FEQ: begin
        res_d.status.NV = any_snan;
        res_d.result[0] = ~any_nan & (ident | both_zero);
      end
      FLT: begin
        res_d.status.NV = any_nan;
        res_d.result[0] = ~any_nan & less & ~both_zero;
      end
      default: begin
        res_d.status.NV = any_nan;
        res_d.result[0] = ~any_nan & (less | ident | both_zero);
      end
    endcase
  end

  fpu_pipe #(
    .payload_t ( out_t          ),
    .DEPTH     ( CMP_PIPE_DEPTH )
  ) i_pipe (
    .clk_i,
    .arst_n_i,
    .flush_i,
    .data_i    ( res_d       ),
    .valid_i   ( in_valid_i  ),
    .ready_o   ( in_ready_o  ),
    .data_o    ( res_q       ),
    .valid_o   ( out_valid_o ),
    .ready_i   ( out_ready_i ),
    .busy_o
  );

  assign result_o = res_q.result;
  assign status_o = res_q.status;
  assign tag_o    = res_q.tag;

endmodule

//--- source/fpu_pipe.sv
`timescale 1ns/100ps

module fpu_pipe #(
  parameter type         payload_t = logic,
  parameter int unsigned DEPTH     = 1
) (
  input  logic     clk_i,
  input  logic     arst_n_i,
  input  logic     flush_i,
  input  payload_t data_i,
  input  logic     valid_i,
  output logic     ready_o,
  output payload_t data_o,
  output logic     valid_o,
  input  logic     ready_i,
  output logic     busy_o
);

  logic [DEPTH-1:0] valid_q;
  payload_t         data_q [DEPTH];
  logic [DEPTH-1:0] stage_in_valid;
  payload_t         stage_in_data [DEPTH];
  logic [DEPTH:0]   stage_ready;

  // Each stage is fed by the one before it, the first by the input port
  always_comb begin
    stage_in_valid[0] = valid_i;
    stage_in_data[0]  = data_i;
    for (int i = 1; i < DEPTH; i++) begin
      stage_in_valid[i] = valid_q[i-1];
      stage_in_data[i]  = data_q[i-1];
    end
  end

  // A stage can load when it is empty or its content moves on
  always_comb begin
    stage_ready[DEPTH] = ready_i;
    for (int i = DEPTH - 1; i >= 0; i--) begin
      stage_ready[i] = ~valid_q[i] | stage_ready[i+1];
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      valid_q <= '0;
    end else if (flush_i) begin
      valid_q <= '0;
    end else begin
      for (int i = 0; i < DEPTH; i++) begin
        if (stage_ready[i]) begin
          valid_q[i] <= stage_in_valid[i];
        end
      end
    end
  end

  always_ff @(posedge clk_i) begin
    for (int i = 0; i < DEPTH; i++) begin
      if (stage_ready[i] && stage_in_valid[i]) begin
        data_q[i] <= stage_in_data[i];
      end
    end
  end

  assign ready_o = stage_ready[0];
  assign valid_o = valid_q[DEPTH-1];
  assign data_o  = data_q[DEPTH-1];
  assign busy_o  = |valid_q;

endmodule

//--- source/fpu_pkg.sv
package fpu_pkg;

  // ---------------------------------------------------------------------
  // Datapath configuration
  // ---------------------------------------------------------------------
  localparam int unsigned FLEN            = 32;
  localparam int unsigned HALF_W          = 16;
  localparam int unsigned NUM_OPERANDS    = 2;
  localparam int unsigned NUM_GROUPS      = 2;
  localparam int unsigned SIGN_PIPE_DEPTH = 1;
  localparam int unsigned CMP_PIPE_DEPTH  = 2;

  // Mantissa widths of the two formats
  localparam int unsigned FP32_MAN_W = 23;
  localparam int unsigned FP16_MAN_W = 10;

  typedef enum logic [3:0] {
    SGNJ, SGNJN, SGNJX, CLASS, MIN, MAX, FEQ, FLT, FLE
  } operation_e;

  typedef enum logic {
    FP32, FP16
  } fp_format_e;

  typedef enum logic {
    SIGN, CMP
  } opgroup_e;

  typedef struct packed {
    logic NV;
    logic DZ;
    logic OF;
    logic UF;
    logic NX;
  } status_t;

  typedef logic [0:NUM_OPERANDS-1][FLEN-1:0] operands_t;
  typedef logic [0:NUM_OPERANDS-1]           boxed_t;

  // Decoded fields of a value, at the width of its format
  typedef struct packed {
    logic sign;
    logic exp_ones;
    logic exp_zero;
    logic man_zero;
    logic quiet;
  } fp_fields_t;

  // ---------------------------------------------------------------------
  // Helper functions
  // ---------------------------------------------------------------------
  function automatic opgroup_e get_opgroup(operation_e op);
    case (op)
      SGNJ, SGNJN, SGNJX, CLASS: return SIGN;
      default:                   return CMP;
    endcase
  endfunction

  function automatic int unsigned fp_width(fp_format_e fmt);
    return (fmt == FP16) ? HALF_W : FLEN;
  endfunction

  function automatic fp_fields_t unpack_fields(logic [FLEN-1:0] value, fp_format_e fmt);
    fp_fields_t f;
    f.sign = value[fp_width(fmt)-1];
    if (fmt == FP16) begin
      f.exp_ones = &value[HALF_W-2:FP16_MAN_W];
      f.exp_zero = ~|value[HALF_W-2:FP16_MAN_W];
      f.man_zero = ~|value[FP16_MAN_W-1:0];
      f.quiet    = value[FP16_MAN_W-1];
    end else begin
      f.exp_ones = &value[FLEN-2:FP32_MAN_W];
      f.exp_zero = ~|value[FLEN-2:FP32_MAN_W];
      f.man_zero = ~|value[FP32_MAN_W-1:0];
      f.quiet    = value[FP32_MAN_W-1];
    end
    return f;
  endfunction

  function automatic logic is_nan(logic [FLEN-1:0] value, fp_format_e fmt);
    fp_fields_t f;
    f = unpack_fields(value, fmt);
    return f.exp_ones & ~f.man_zero;
  endfunction

  function automatic logic is_snan(logic [FLEN-1:0] value, fp_format_e fmt);
    return is_nan(value, fmt) & ~unpack_fields(value, fmt).quiet;
  endfunction

  // RISC-V class mask, bit 0 is -inf and bit 9 is quiet NaN
  function automatic logic [9:0] classify_mask(logic [FLEN-1:0] value, fp_format_e fmt);
    fp_fields_t f;
    logic [9:0] mask;
    f    = unpack_fields(value, fmt);
    mask = '0;
    if (is_nan(value, fmt)) begin
      mask[9] = f.quiet;
      mask[8] = ~f.quiet;
    end else if (f.exp_ones) begin
      mask[f.sign ? 0 : 7] = 1'b1;
    end else if (f.exp_zero && f.man_zero) begin
      mask[f.sign ? 3 : 4] = 1'b1;
    end else if (f.exp_zero) begin
      mask[f.sign ? 2 : 5] = 1'b1;
    end else begin
      mask[f.sign ? 1 : 6] = 1'b1;
    end
    return mask;
  endfunction

  function automatic logic [FLEN-1:0] canonical_nan(fp_format_e fmt);
    return (fmt == FP16) ? 32'hFFFF_7E00 : 32'h7FC0_0000;
  endfunction

endpackage

//--- source/fpu_rr_arbiter.sv
`timescale 1ns/100ps

module fpu_rr_arbiter #(
  parameter type         payload_t = logic,
  parameter int unsigned N         = 2
) (
  input  logic         clk_i,
  input  logic         arst_n_i,
  input  logic         flush_i,
  input  payload_t     inp_data_i [N],
  input  logic [N-1:0] inp_valid_i,
  output logic [N-1:0] inp_ready_o,
  output payload_t     oup_data_o,
  output logic         oup_valid_o,
  input  logic         oup_ready_i
);

  localparam int unsigned IDX_W = (N > 1) ? $clog2(N) : 1;

  logic [IDX_W-1:0] rr_q;
  logic [IDX_W-1:0] lock_idx_q;
  logic             lock_q;
  logic [IDX_W-1:0] sel;

  // First valid input at or after the pointer, held while stalled
  always_comb begin
    int unsigned cand;
    logic        found;
    sel   = rr_q;
    found = 1'b0;
    for (int unsigned i = 0; i < N; i++) begin
      cand = int'(rr_q) + i;
      if (cand >= N) begin
        cand = cand - N;
      end
      if (!found && inp_valid_i[cand]) begin
        sel   = IDX_W'(cand);
        found = 1'b1;
      end
    end
    if (lock_q) begin
      sel = lock_idx_q;
    end
  end

  always_comb begin
    for (int unsigned i = 0; i < N; i++) begin
      inp_ready_o[i] = oup_ready_i && (sel == IDX_W'(i));
    end
  end

  assign oup_valid_o = inp_valid_i[sel];
  assign oup_data_o  = inp_data_i[sel];

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      rr_q       <= '0;
      lock_q     <= 1'b0;
      lock_idx_q <= '0;
    end else begin
      if (oup_valid_o && oup_ready_i) begin
        rr_q   <= (sel == IDX_W'(N - 1)) ? '0 : sel + 1'b1;
        lock_q <= 1'b0;
      end else if (oup_valid_o) begin
        lock_q     <= 1'b1;
        lock_idx_q <= sel;
      end
      // Flush releases the grant, the pointer stays where it is
      if (flush_i) begin
        lock_q <= 1'b0;
      end
    end
  end

endmodule

//--- source/fpu_sign_group.sv
`timescale 1ns/100ps

module fpu_sign_group #(
  parameter type TagType = logic
) (
  input  logic                      clk_i,
  input  logic                      arst_n_i,
  input  logic                      flush_i,
  input  fpu_pkg::operands_t        operands_i,
  input  fpu_pkg::boxed_t           boxed_i,
  input  fpu_pkg::operation_e       op_i,
  input  fpu_pkg::fp_format_e       fmt_i,
  input  TagType                    tag_i,
  input  logic                      in_valid_i,
  output logic                      in_ready_o,
  output logic [fpu_pkg::FLEN-1:0]  result_o,
  output fpu_pkg::status_t          status_o,
  output TagType                    tag_o,
  output logic                      out_valid_o,
  input  logic                      out_ready_i,
  output logic                      busy_o
);

  import fpu_pkg::*;

  typedef struct packed {
    logic [FLEN-1:0] result;
    status_t         status;
    TagType          tag;
  } out_t;

  logic [FLEN-1:0] opa;
  logic [FLEN-1:0] opb;
  logic            new_sign;
  out_t            res_d;
  out_t            res_q;

  // Unboxed inputs are replaced by the canonical NaN
  assign opa = boxed_i[0] ? operands_i[0] : canonical_nan(fmt_i);
  assign opb = boxed_i[1] ? operands_i[1] : canonical_nan(fmt_i);

  always_comb begin
    case (op_i)
      SGNJN:   new_sign = ~opb[fp_width(fmt_i)-1];
      SGNJX:   new_sign = opa[fp_width(fmt_i)-1] ^ opb[fp_width(fmt_i)-1];
      default: new_sign = opb[fp_width(fmt_i)-1];
    endcase

    res_d.status = '0;
    res_d.tag    = tag_i;
    if (op_i == CLASS) begin
      res_d.result = FLEN'(classify_mask(opa, fmt_i));
    end else if (fmt_i == FP16) begin
      // Magnitude of A with the new sign, boxed again
      res_d.result = {{(FLEN-HALF_W){1'b1}}, new_sign, opa[HALF_W-2:0]};
    end else begin
      res_d.result = {new_sign, opa[FLEN-2:0]};
    end
  end

  fpu_pipe #(
    .payload_t ( out_t           ),
    .DEPTH     ( SIGN_PIPE_DEPTH )
  ) i_pipe (
    .clk_i,
    .arst_n_i,
    .flush_i,
    .data_i    ( res_d       ),
    .valid_i   ( in_valid_i  ),
    .ready_o   ( in_ready_o  ),
    .data_o    ( res_q       ),
    .valid_o   ( out_valid_o ),
    .ready_i   ( out_ready_i ),
    .busy_o
  );

  assign result_o = res_q.result;
  assign status_o = res_q.status;
  assign tag_o    = res_q.tag;

endmodule

//--- source/fpu_top.sv
`timescale 1ns/100ps

module fpu_top #(
  parameter type TagType = logic
) (
  input  logic                      clk_i,
  input  logic                      arst_n_i,
  // Request
  input  fpu_pkg::operands_t        operands_i,
  input  fpu_pkg::operation_e       op_i,
  input  fpu_pkg::fp_format_e       fmt_i,
  input  TagType                    tag_i,
  input  logic                      in_valid_i,
  output logic                      in_ready_o,
  input  logic                      flush_i,
  // Answer
  output logic [fpu_pkg::FLEN-1:0]  result_o,
  output fpu_pkg::status_t          status_o,
  output TagType                    tag_o,
  output logic                      out_valid_o,
  input  logic                      out_ready_i,
  output logic                      busy_o
);

  import fpu_pkg::*;

  typedef struct packed {
    logic [FLEN-1:0] result;
    status_t         status;
    TagType          tag;
  } output_t;

  opgroup_e                group;
  boxed_t                  boxed;
  logic [NUM_GROUPS-1:0]   grp_in_valid;
  logic [NUM_GROUPS-1:0]   grp_in_ready;
  logic [NUM_GROUPS-1:0]   grp_out_valid;
  logic [NUM_GROUPS-1:0]   grp_out_ready;
  logic [NUM_GROUPS-1:0]   grp_busy;
  output_t                 grp_out [NUM_GROUPS];
  output_t                 arb_out;

  // ---------------------------------------------------------------------
  // Decode and NaN-box check
  // ---------------------------------------------------------------------
  assign group = get_opgroup(op_i);

  always_comb begin
    for (int i = 0; i < NUM_OPERANDS; i++) begin
      boxed[i] = (fmt_i == FP32) || (&operands_i[i][FLEN-1:HALF_W]);
    end
  end

  always_comb begin
    for (int g = 0; g < NUM_GROUPS; g++) begin
      grp_in_valid[g] = in_valid_i && (group == opgroup_e'(g));
    end
  end

  assign in_ready_o = in_valid_i & grp_in_ready[group];

  // ---------------------------------------------------------------------
  // Operation groups
  // ---------------------------------------------------------------------
  fpu_sign_group #(
    .TagType ( TagType )
  ) i_sign_group (
    .clk_i,
    .arst_n_i,
    .flush_i,
    .operands_i,
    .boxed_i     ( boxed                   ),
    .op_i,
    .fmt_i,
    .tag_i,
    .in_valid_i  ( grp_in_valid[SIGN]      ),
    .in_ready_o  ( grp_in_ready[SIGN]      ),
    .result_o    ( grp_out[SIGN].result    ),
    .status_o    ( grp_out[SIGN].status    ),
    .tag_o       ( grp_out[SIGN].tag       ),
    .out_valid_o ( grp_out_valid[SIGN]     ),
    .out_ready_i ( grp_out_ready[SIGN]     ),
    .busy_o      ( grp_busy[SIGN]          )
  );

  fpu_cmp_group #(
    .TagType ( TagType )
  ) i_cmp_group (
    .clk_i,
    .arst_n_i,
    .flush_i,
    .operands_i,
    .boxed_i     ( boxed                  ),
    .op_i,
    .fmt_i,
    .tag_i,
    .in_valid_i  ( grp_in_valid[CMP]      ),
    .in_ready_o  ( grp_in_ready[CMP]      ),
    .result_o    ( grp_out[CMP].result    ),
    .status_o    ( grp_out[CMP].status    ),
    .tag_o       ( grp_out[CMP].tag       ),
    .out_valid_o ( grp_out_valid[CMP]     ),
    .out_ready_i ( grp_out_ready[CMP]     ),
    .busy_o      ( grp_busy[CMP]          )
  );

  // Merge of the group results
  fpu_rr_arbiter #(
    .payload_t ( output_t   ),
    .N         ( NUM_GROUPS )
  ) i_arbiter (
    .clk_i,
    .arst_n_i,
    .flush_i,
    .inp_data_i  ( grp_out       ),
    .inp_valid_i ( grp_out_valid ),
    .inp_ready_o ( grp_out_ready ),
    .oup_data_o  ( arb_out       ),
    .oup_valid_o ( out_valid_o   ),
    .oup_ready_i ( out_ready_i   )
  );

  assign result_o = arb_out.result;
  assign status_o = arb_out.status;
  assign tag_o    = arb_out.tag;
  assign busy_o   = |grp_busy;

endmodule

//--- test/fpu_tb.sv
`timescale 1ns/100ps

module fpu_tb;

  import fpu_pkg::*;

  typedef logic [5:0] tag_t;

  localparam int NUM_REQ        = 4 * 60 + 200 + 16 + 20;
  localparam int TIMEOUT_CYCLES = 4 * NUM_REQ * 20;
  localparam int CLK_PERIOD     = 8;

  logic       clk_i = 1'b0;
  logic       arst_n_i;
  operands_t  operands_i;
  operation_e op_i;
  fp_format_e fmt_i;
  tag_t       tag_i;
  logic       in_valid_i;
  logic       in_ready_o;
  logic       flush_i;
  logic [FLEN-1:0] result_o;
  status_t    status_o;
  tag_t       tag_o;
  logic       out_valid_o;
  logic       out_ready_i;
  logic       busy_o;

  logic [31:0] lfsr_q = 32'h6812af32;
  int          ready_mode;
  string       cur_test;
  tag_t        next_tag;
  int          pend_count;
  bit          pending [64];
  bit          dropped [64];
  logic [31:0] exp_res [64];
  logic [4:0]  exp_st [64];
  string       tag_test [64];

  fpu_top #(
    .TagType ( tag_t )
  ) i_fpu_top (
    .clk_i,
    .arst_n_i,
    .operands_i,
    .op_i,
    .fmt_i,
    .tag_i,
    .in_valid_i,
    .in_ready_o,
    .flush_i,
    .result_o,
    .status_o,
    .tag_o,
    .out_valid_o,
    .out_ready_i,
    .busy_o
  );

  always #(CLK_PERIOD / 2) clk_i = ~clk_i;

  task automatic report_failure(input string what);
    $display("%s", what);
    $display("TEST FAIL");
    $fatal(1);
  endtask

  // ---------------------------------------------------------------------
  // Random source
  // ---------------------------------------------------------------------
  function automatic logic [31:0] lfsr_next(logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'hB4BC_D35C) : (s >> 1);
  endfunction

  // One LFSR step per bit
  task automatic draw(input int n, output logic [31:0] val);
    val = '0;
    for (int i = 0; i < n; i++) begin
      val    = {val[30:0], lfsr_q[0]};
      lfsr_q = lfsr_next(lfsr_q);
    end
  endtask

  // ---------------------------------------------------------------------
  // Reference model
  // ---------------------------------------------------------------------
  function automatic logic [31:0] unbox(logic [31:0] v, fp_format_e fmt);
    if (fmt == FP16 && v[31:16] != 16'hFFFF) begin
      return 32'hFFFF_7E00;
    end
    return v;
  endfunction

  function automatic logic sign_of(logic [31:0] v, fp_format_e fmt);
    return (fmt == FP16) ? v[15] : v[31];
  endfunction

  function automatic logic [31:0] mag_of(logic [31:0] v, fp_format_e fmt);
    return (fmt == FP16) ? {17'h0, v[14:0]} : {1'b0, v[30:0]};
  endfunction

  function automatic logic quiet_of(logic [31:0] v, fp_format_e fmt);
    return (fmt == FP16) ? v[9] : v[22];
  endfunction

  function automatic logic nan_of(logic [31:0] v, fp_format_e fmt);
    if (fmt == FP16) begin
      return (v[14:10] == 5'h1F) && (v[9:0] != 0);
    end
    return (v[30:23] == 8'hFF) && (v[22:0] != 0);
  endfunction

  // Total order key where -0 sits just below +0
  function automatic logic signed [33:0] key_of(logic [31:0] v, fp_format_e fmt);
    logic signed [33:0] m;
    m = $signed({2'b00, mag_of(v, fmt)});
    return sign_of(v, fmt) ? (-m - 34'sd1) : m;
  endfunction

  function automatic logic [9:0] class_of(logic [31:0] v, fp_format_e fmt);
    logic e_all;
    logic e_zero;
    logic m_zero;
    logic s;
    s      = sign_of(v, fmt);
    e_all  = (fmt == FP16) ? (v[14:10] == 5'h1F) : (v[30:23] == 8'hFF);
    e_zero = (fmt == FP16) ? (v[14:10] == 5'h00) : (v[30:23] == 8'h00);
    m_zero = (fmt == FP16) ? (v[9:0] == 0) : (v[22:0] == 0);
    if (e_all && !m_zero) begin
      return quiet_of(v, fmt) ? 10'h200 : 10'h100;
    end
    if (e_all) return s ? 10'h001 : 10'h080;
    if (e_zero && m_zero) return s ? 10'h008 : 10'h010;
    if (e_zero) return s ? 10'h004 : 10'h020;
    return s ? 10'h002 : 10'h040;
  endfunction

  // Result in the upper 32 bits, status flags below
  function automatic logic [36:0] model(operation_e op, fp_format_e fmt,
                                        logic [31:0] a_in, logic [31:0] b_in);
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] res;
    logic        na;
    logic        nb;
    logic        sn;
    logic        nv;
    logic        zz;
    logic        eq;
    logic        lt;
    logic        s;
    a   = unbox(a_in, fmt);
    b   = unbox(b_in, fmt);
    na  = nan_of(a, fmt);
    nb  = nan_of(b, fmt);
    sn  = (na && !quiet_of(a, fmt)) || (nb && !quiet_of(b, fmt));
    zz  = (mag_of(a, fmt) == 0) && (mag_of(b, fmt) == 0);
    eq  = !na && !nb && ((a == b) || zz);
    lt  = !na && !nb && !zz && (key_of(a, fmt) < key_of(b, fmt));
    res = '0;
    nv  = 1'b0;
    case (op)
      SGNJ, SGNJN, SGNJX: begin
        if (op == SGNJ) s = sign_of(b, fmt);
        else if (op == SGNJN) s = !sign_of(b, fmt);
        else s = sign_of(a, fmt) ^ sign_of(b, fmt);
        res = (fmt == FP16) ? {16'hFFFF, s, a[14:0]} : {s, a[30:0]};
      end
      CLASS: res = {22'h0, class_of(a, fmt)};
      MIN, MAX: begin
        nv = sn;
        if (na && nb) res = (fmt == FP16) ? 32'hFFFF_7E00 : 32'h7FC0_0000;
        else if (na) res = b;
        else if (nb) res = a;
        else if (op == MIN) res = (key_of(a, fmt) < key_of(b, fmt)) ? a : b;
        else res = (key_of(a, fmt) > key_of(b, fmt)) ? a : b;
      end
      FEQ: begin
        nv  = sn;
        res = {31'h0, eq};
      end
      FLT: begin
        nv  = na || nb;
        res = {31'h0, lt};
      end
      default: begin
        nv  = na || nb;
        res = {31'h0, lt || eq};
      end
    endcase
    return {res, nv, 4'b0000};
  endfunction

  // ---------------------------------------------------------------------
  // Stimulus
  // ---------------------------------------------------------------------
  task automatic make_operand(input fp_format_e fmt, output logic [31:0] v);
    logic [31:0] kind;
    logic [31:0] raw;
    logic [31:0] up;
    draw(3, kind);
    draw(32, raw);
    if (fmt == FP32) begin
      case (kind)
        0:       v = {raw[31], 31'h0};
        1:       v = {raw[31], 8'hFF, 23'h0};
        2:       v = {raw[31], 8'hFF, 1'b1, raw[21:0]};
        3:       v = {raw[31], 8'hFF, 1'b0, raw[21:1], 1'b1};
        4:       v = {raw[31], 8'h00, raw[22:0]};
        default: v = raw;
      endcase
    end else begin
      case (kind)
        0:       v[15:0] = {raw[15], 15'h0};
        1:       v[15:0] = {raw[15], 5'h1F, 10'h0};
        2:       v[15:0] = {raw[15], 5'h1F, 1'b1, raw[8:0]};
        3:       v[15:0] = {raw[15], 5'h1F, 1'b0, raw[8:1], 1'b1};
        4:       v[15:0] = {raw[15], 5'h00, raw[9:0]};
        default: v[15:0] = raw[15:0];
      endcase
      // Now and then a broken NaN box
      draw(3, up);
      v[31:16] = (up == 0) ? (raw[31:16] & 16'h7FFF) : 16'hFFFF;
    end
  endtask

  task automatic step_cycle(output bit acc);
    logic [31:0] r;
    @(posedge clk_i);
    acc = in_valid_i && in_ready_o;
    #1;
    case (ready_mode)
      0: out_ready_i = 1'b1;
      1: begin
        draw(1, r);
        out_ready_i = r[0];
      end
      default: out_ready_i = 1'b0;
    endcase
  endtask

  task automatic issue(input int op_lo, input int op_span);
    logic [31:0] r;
    logic [31:0] a;
    logic [31:0] b;
    bit          acc;
    draw(1, r);
    fmt_i = fp_format_e'(r[0]);
    make_operand(fmt_i, a);
    make_operand(fmt_i, b);
    draw(3, r);
    if (r == 0) b = a;
    draw(4, r);
    op_i          = operation_e'(op_lo + int'(r) % op_span);
    operands_i[0] = a;
    operands_i[1] = b;
    tag_i         = next_tag;
    in_valid_i    = 1'b1;
    acc           = 1'b0;
    while (!acc) step_cycle(acc);
    in_valid_i = 1'b0;
    next_tag   = next_tag + 1'b1;
    draw(2, r);
    if (r == 0) step_cycle(acc);
  endtask

  task automatic run_phase(input string name, input int op_lo, input int op_span,
                           input int count, input int mode);
    cur_test   = name;
    ready_mode = mode;
    repeat (count) issue(op_lo, op_span);
  endtask

  // ---------------------------------------------------------------------
  // Scoreboard
  // ---------------------------------------------------------------------
  always @(posedge clk_i) begin : monitor
    tag_t        t;
    logic [36:0] m;
    if (arst_n_i) begin
      assert (i_fpu_top.i_assert.fail_count == 0)
        else report_failure("A protocol assertion on the DUT outputs failed");
      if (out_valid_o && out_ready_i) begin
        t = tag_o;
        assert (!dropped[t])
          else report_failure($sformatf("Tag %0d of a flushed request came out", t));
        assert (pending[t])
          else report_failure($sformatf("Tag %0d came out but was not in flight", t));
        assert (result_o === exp_res[t])
          else report_failure($sformatf("ERR %s tag %0d result expected %h actual %h",
                                        tag_test[t], t, exp_res[t], result_o));
        assert (status_o === exp_st[t])
          else report_failure($sformatf("ERR %s tag %0d status expected %b actual %b",
                                        tag_test[t], t, exp_st[t], status_o));
        pending[t] = 1'b0;
        pend_count--;
      end
      if (in_valid_i && in_ready_o) begin
        t = tag_i;
        assert (!pending[t])
          else report_failure($sformatf("Tag %0d accepted while still in flight", t));
        m            = model(op_i, fmt_i, operands_i[0], operands_i[1]);
        exp_res[t]   = m[36:5];
        exp_st[t]    = m[4:0];
        tag_test[t]  = cur_test;
        pending[t]   = 1'b1;
        dropped[t]   = 1'b0;
        pend_count++;
      end
      // Everything in flight is lost on a flush
      if (flush_i) begin
        for (int i = 0; i < 64; i++) begin
          if (pending[i]) begin
            pending[i] = 1'b0;
            dropped[i] = 1'b1;
          end
        end
        pend_count = 0;
      end
    end
  end

  initial begin : watchdog
    #(TIMEOUT_CYCLES * CLK_PERIOD);
    report_failure("Watchdog expired because the DUT stalled and the run did not finish");
  end

  initial begin : driver
    bit acc;
    arst_n_i    = 1'b0;
    operands_i  = '0;
    op_i        = SGNJ;
    fmt_i       = FP32;
    tag_i       = '0;
    in_valid_i  = 1'b0;
    flush_i     = 1'b0;
    out_ready_i = 1'b1;
    ready_mode  = 0;
    next_tag    = '0;
    pend_count  = 0;
    cur_test    = "reset";
    repeat (4) @(posedge clk_i);
    #1;
    arst_n_i = 1'b1;
    step_cycle(acc);

    run_phase("sign_inject", 0, 3, 60, 0);
    run_phase("classify", 3, 1, 60, 0);
    run_phase("min_max", 4, 2, 60, 0);
    run_phase("compare", 6, 3, 60, 0);
    run_phase("mixed_stall", 0, 9, 200, 1);

    // Build up traffic, hold the output, then flush
    repeat (4) begin
      run_phase("flush", 0, 9, 4, 1);
      ready_mode = 2;
      repeat (2) step_cycle(acc);
      flush_i = 1'b1;
      step_cycle(acc);
      flush_i = 1'b0;
    end
    run_phase("after_flush", 0, 9, 20, 1);

    cur_test   = "drain";
    ready_mode = 0;
    while (busy_o) step_cycle(acc);
    step_cycle(acc);
    if (pend_count == 0 && i_fpu_top.i_assert.fail_count == 0) begin
      $display("TEST PASS");
      $finish;
    end else begin
      report_failure("Scoreboard not empty or a protocol assertion failed at the end");
    end
  end

endmodule

//--- test/fpu_tb_assert.sv
`timescale 1ns/100ps

module fpu_tb_assert #(
  parameter type TagType = logic
) (
  input logic                     clk_i,
  input logic                     arst_n_i,
  input logic                     flush_i,
  input logic                     out_valid_o,
  input logic                     out_ready_i,
  input logic                     busy_o,
  input logic [fpu_pkg::FLEN-1:0] result_o,
  input fpu_pkg::status_t         status_o,
  input TagType                   tag_o
);

  int unsigned fail_count = 0;

  // Output held while the consumer stalls
  a_hold: assert property (@(posedge clk_i) disable iff (!arst_n_i)
      out_valid_o && !out_ready_i && !flush_i |=>
        out_valid_o && $stable(result_o) && $stable(status_o) && $stable(tag_o))
    else begin
      $error("output payload or valid changed while stalled");
      fail_count++;
    end

  a_reset: assert property (@(posedge clk_i)
      (!arst_n_i || $rose(arst_n_i)) |-> !out_valid_o && !busy_o)
    else begin
      $error("output valid or busy high in or right after reset");
      fail_count++;
    end

  a_flush: assert property (@(posedge clk_i) disable iff (!arst_n_i)
      flush_i |=> !out_valid_o && !busy_o)
    else begin
      $error("output valid or busy high one cycle after flush");
      fail_count++;
    end

  a_busy: assert property (@(posedge clk_i) disable iff (!arst_n_i)
      out_valid_o |-> busy_o)
    else begin
      $error("output valid without busy");
      fail_count++;
    end

endmodule

bind fpu_top fpu_tb_assert #(
  .TagType ( TagType )
) i_assert (
  .clk_i,
  .arst_n_i,
  .flush_i,
  .out_valid_o,
  .out_ready_i,
  .busy_o,
  .result_o,
  .status_o,
  .tag_o
);
